//--- verilog.f
design/fc_irq_pkg.sv
design/fc_event_if.sv
design/fc_event_regs.sv
design/fc_event_fifo.sv
design/fc_irq_arbiter.sv
design/fc_irq_line_map.sv
design/fc_irq_subsystem.sv
test/tb_fc_irq_subsystem.sv

//--- Makefile
TOP = tb_fc_irq_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_fc_irq_subsystem.sv
// Table driven testbench for the fabric controller interrupt path.
// Each row is one operation on the DUT ports plus the outputs expected
// after the clock edge that samples it. Compile with verilog.f.
module tb_fc_irq_subsystem;

    localparam logic [2:0] OP_IDLE  = 3'd0;
    localparam logic [2:0] OP_WR    = 3'd1;
    localparam logic [2:0] OP_RD    = 3'd2;
    localparam logic [2:0] OP_EVT   = 3'd3;
    localparam logic [2:0] OP_PUSH  = 3'd4;
    localparam logic [2:0] OP_ACK   = 3'd5;
    localparam logic [2:0] OP_FETCH = 3'd6;  // level on fetch_en_i
    localparam logic [31:0] DELIV   = (32'h1 << 26) | 32'h0000_7FFF;

    typedef struct packed {
        logic [2:0]  op;
        logic [2:0]  addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [14:0] fast;
        logic        fulln;
        logic        fetch;
    } row_t;

    logic        clk;
    logic        rst;
    logic [31:0] events;
    logic        fifo_valid;
    logic [7:0]  fifo_data;
    logic        fifo_fulln;
    logic        cfg_we;
    logic        cfg_re;
    logic [2:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic [14:0] irq_fast;
    logic        irq_ack;
    logic [3:0]  ack_line;
    logic        fetch_en;
    logic        fetch_en_out;

    row_t        rows[$];
    logic [7:0]  fifo_ids[5];
    integer      seed = 32;
    int          err_cnt = 0;
    int          fail_rows = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    fc_irq_subsystem #(.EVENT_FIFO_DEPTH(4)) i_dut (
        .clk_i              ( clk          ),
        .rst_i              ( rst          ),
        .events_i           ( events       ),
        .event_fifo_valid_i ( fifo_valid   ),
        .event_fifo_data_i  ( fifo_data    ),
        .event_fifo_fulln_o ( fifo_fulln   ),
        .cfg_we_i           ( cfg_we       ),
        .cfg_re_i           ( cfg_re       ),
        .cfg_addr_i         ( cfg_addr     ),
        .cfg_wdata_i        ( cfg_wdata    ),
        .cfg_rdata_o        ( cfg_rdata    ),
        .irq_fast_o         ( irq_fast     ),
        .irq_ack_i          ( irq_ack      ),
        .irq_ack_line_i     ( ack_line     ),
        .fetch_en_i         ( fetch_en     ),
        .fetch_en_o         ( fetch_en_out )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic add_row(input logic [2:0] op, input logic [2:0] addr,
                           input logic [31:0] data, input logic [31:0] rdata,
                           input logic [14:0] fast, input logic fulln, input logic fetch);
        row_t r;
        r = '{op, addr, data, rdata, fast, fulln, fetch};
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        events     = '0;
        fifo_valid = 1'b0;
        cfg_we     = 1'b0;
        cfg_re     = 1'b0;
        irq_ack    = 1'b0;
        cfg_addr   = r.addr;
        cfg_wdata  = r.data;
        fifo_data  = r.data[7:0];
        ack_line   = r.data[3:0];
        case (r.op)
            OP_WR:    cfg_we = 1'b1;
            OP_RD:    cfg_re = 1'b1;
            OP_EVT:   events = r.data;
            OP_PUSH:  fifo_valid = 1'b1;
            OP_ACK:   irq_ack = 1'b1;
            OP_FETCH: fetch_en = r.data[0];
            default:  ;
        endcase
    endtask

    task automatic check_row(input int idx, input row_t r);
        int errs_before;
        errs_before = err_cnt;
        assert (cfg_rdata === r.rdata) else begin
            err_cnt++;
            $display("Mismatch row %0d cfg_rdata_o: got %h, expected %h",
                     idx, cfg_rdata, r.rdata);
        end
        assert (irq_fast === r.fast) else begin
            err_cnt++;
            $display("Mismatch row %0d irq_fast_o: got %h, expected %h", idx, irq_fast, r.fast);
        end
        assert (fifo_fulln === r.fulln) else begin
            err_cnt++;
            $display("Mismatch row %0d event_fifo_fulln_o: got %h, expected %h",
                     idx, fifo_fulln, r.fulln);
        end
        assert (fetch_en_out === r.fetch) else begin
            err_cnt++;
            $display("Mismatch row %0d fetch_en_o: got %h, expected %h",
                     idx, fetch_en_out, r.fetch);
        end
        if (err_cnt == errs_before) $display("row %0d op %0d ok", idx, r.op);
        else fail_rows++;
    endtask

    //******************************
    // stimulus table
    //******************************
    task automatic build_table();
        // reset values
        add_row(OP_IDLE, 3'd0, 32'h0, 32'h0, 15'h0000, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_MASK, 32'h0, 32'h0, 15'h0000, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_CTRL, 32'h0, 32'h1, 15'h0000, 1, 1);
        // masked delivery with bits 3 5 7 open
        add_row(OP_WR, fc_irq_pkg::REG_MASK, 32'hA8, 32'h1, 15'h0000, 1, 1);
        add_row(OP_EVT, 3'd0, 32'h20, 32'h1, 15'h0020, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_MASK, 32'h0, 32'hA8, 15'h0020, 1, 1);
        add_row(OP_ACK, 3'd0, 32'd5, 32'hA8, 15'h0000, 1, 1);
        add_row(OP_EVT, 3'd0, 32'h02, 32'hA8, 15'h0000, 1, 1);   // masked
        add_row(OP_RD, fc_irq_pkg::REG_PENDING, 32'h0, 32'h2, 15'h0000, 1, 1);
        add_row(OP_WR, fc_irq_pkg::REG_PENDING_CLR, 32'h2, 32'h2, 15'h0000, 1, 1);
        // priority goes to the lowest id
        add_row(OP_EVT, 3'd0, 32'h88, 32'h2, 15'h0008, 1, 1);
        add_row(OP_ACK, 3'd0, 32'd3, 32'h2, 15'h0080, 1, 1);
        add_row(OP_ACK, 3'd0, 32'd7, 32'h2, 15'h0000, 1, 1);
        // software pending and deliverable mask
        add_row(OP_WR, fc_irq_pkg::REG_MASK, 32'hFFFF_FFFF, 32'h2, 15'h0000, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_MASK, 32'h0, DELIV, 15'h0000, 1, 1);
        add_row(OP_WR, fc_irq_pkg::REG_PENDING, 32'h0010_1000, DELIV, 15'h1000, 1, 1);
        add_row(OP_WR, fc_irq_pkg::REG_PENDING_CLR, 32'h1000, DELIV, 15'h0000, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_PENDING, 32'h0, 32'h0010_0000, 15'h0000, 1, 1);
        add_row(OP_WR, fc_irq_pkg::REG_PENDING_CLR, 32'h0010_0000, 32'h0010_0000,
                15'h0000, 1, 1);
        // event FIFO on line 10
        add_row(OP_PUSH, 3'd0, 32'(fifo_ids[0]), 32'h0010_0000, 15'h0400, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_FIFO_HEAD, 32'h0, 32'(fifo_ids[0]), 15'h0400, 1, 1);
        add_row(OP_PUSH, 3'd0, 32'(fifo_ids[1]), 32'(fifo_ids[0]), 15'h0400, 1, 1);
        add_row(OP_PUSH, 3'd0, 32'(fifo_ids[2]), 32'(fifo_ids[0]), 15'h0400, 1, 1);
        add_row(OP_PUSH, 3'd0, 32'(fifo_ids[3]), 32'(fifo_ids[0]), 15'h0400, 0, 1);
        add_row(OP_PUSH, 3'd0, 32'(fifo_ids[4]), 32'(fifo_ids[0]), 15'h0400, 0, 1); // dropped
        add_row(OP_EVT, 3'd0, 32'h08, 32'(fifo_ids[0]), 15'h0008, 0, 1);
        add_row(OP_ACK, 3'd0, 32'd3, 32'(fifo_ids[0]), 15'h0400, 0, 1);
        add_row(OP_ACK, 3'd0, 32'd10, 32'(fifo_ids[0]), 15'h0400, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_FIFO_HEAD, 32'h0, 32'(fifo_ids[1]), 15'h0400, 1, 1);
        add_row(OP_ACK, 3'd0, 32'd10, 32'(fifo_ids[1]), 15'h0400, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_FIFO_HEAD, 32'h0, 32'(fifo_ids[2]), 15'h0400, 1, 1);
        add_row(OP_ACK, 3'd0, 32'd10, 32'(fifo_ids[2]), 15'h0400, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_FIFO_HEAD, 32'h0, 32'(fifo_ids[3]), 15'h0400, 1, 1);
        add_row(OP_ACK, 3'd0, 32'd10, 32'(fifo_ids[3]), 15'h0000, 1, 1);
        // fetch enable gating
        add_row(OP_WR, fc_irq_pkg::REG_CTRL, 32'h0, 32'(fifo_ids[3]), 15'h0000, 1, 0);
        add_row(OP_RD, fc_irq_pkg::REG_CTRL, 32'h0, 32'h0, 15'h0000, 1, 0);
        add_row(OP_FETCH, 3'd0, 32'h0, 32'h0, 15'h0000, 1, 0);
        add_row(OP_WR, fc_irq_pkg::REG_CTRL, 32'h1, 32'h0, 15'h0000, 1, 0);
        add_row(OP_FETCH, 3'd0, 32'h1, 32'h0, 15'h0000, 1, 1);
        add_row(OP_RD, fc_irq_pkg::REG_CTRL, 32'h0, 32'h1, 15'h0000, 1, 1);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        events     = '0;
        fifo_valid = 1'b0;
        fifo_data  = '0;
        cfg_we     = 1'b0;
        cfg_re     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        irq_ack    = 1'b0;
        ack_line   = '0;
        fetch_en   = 1'b1;
        for (int k = 0; k < 5; k++) fifo_ids[k] = 8'($random(seed));
        build_table();
        cycle_limit = rows.size() * 4 + 16;
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        // check the previous row, then drive this one
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #2;
            if (i > 0) check_row(i - 1, rows[i - 1]);
            drive_row(rows[i]);
        end
        @(posedge clk);
        #2;
        check_row(rows.size() - 1, rows[rows.size() - 1]);
        $display("rows %0d, failed rows %0d, mismatches %0d", rows.size(), fail_rows, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- design/fc_irq_subsystem.sv
// Interrupt path of the fabric controller: event FIFO, pending and mask
// registers, priority selection and the mapping onto fast lines.
// Configuration goes through a strobe register port, the core side is
// the fast line vector plus an acknowledge strobe and line.
module fc_irq_subsystem #(
    parameter int EVENT_FIFO_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  fc_irq_pkg::irq_vec_t   events_i,
    input  logic                   event_fifo_valid_i,
    input  fc_irq_pkg::event_id_t  event_fifo_data_i,
    output logic                   event_fifo_fulln_o,
    input  logic                   cfg_we_i,
    input  logic                   cfg_re_i,
    input  fc_irq_pkg::cfg_addr_t  cfg_addr_i,
    input  fc_irq_pkg::cfg_data_t  cfg_wdata_i,
    output fc_irq_pkg::cfg_data_t  cfg_rdata_o,
    output fc_irq_pkg::fast_vec_t  irq_fast_o,
    input  logic                   irq_ack_i,
    input  fc_irq_pkg::fast_line_t irq_ack_line_i,
    input  logic                   fetch_en_i,
    output logic                   fetch_en_o
);

    fc_irq_pkg::event_id_t fifo_head;
    logic                  fifo_not_empty;
    logic                  fifo_pop;
    logic                  core_irq_req;
    fc_irq_pkg::irq_id_t   core_irq_id;
    logic                  core_irq_ack;
    fc_irq_pkg::irq_id_t   core_irq_ack_id;

    fc_event_if i_ev ();

    fc_event_regs i_regs (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .cfg_we_i    ( cfg_we_i    ),
        .cfg_re_i    ( cfg_re_i    ),
        .cfg_addr_i  ( cfg_addr_i  ),
        .cfg_wdata_i ( cfg_wdata_i ),
        .cfg_rdata_o ( cfg_rdata_o ),
        .fifo_head_i ( fifo_head   ),
        .fetch_en_i  ( fetch_en_i  ),
        .fetch_en_o  ( fetch_en_o  ),
        .ev          ( i_ev.regs   )
    );

    fc_event_fifo #(
        .EVENT_FIFO_DEPTH ( EVENT_FIFO_DEPTH )
    ) i_fifo (
        .clk_i       ( clk_i              ),
        .rst_i       ( rst_i              ),
        .push_i      ( event_fifo_valid_i ),
        .data_i      ( event_fifo_data_i  ),
        .pop_i       ( fifo_pop           ),
        .fulln_o     ( event_fifo_fulln_o ),
        .head_o      ( fifo_head          ),
        .not_empty_o ( fifo_not_empty     )
    );

    fc_irq_arbiter i_arbiter (
        .clk_i      ( clk_i           ),
        .rst_i      ( rst_i           ),
        .events_i   ( events_i        ),
        .fifo_irq_i ( fifo_not_empty  ),
        .ack_i      ( core_irq_ack    ),
        .ack_id_i   ( core_irq_ack_id ),
        .req_o      ( core_irq_req    ),
        .id_o       ( core_irq_id     ),
        .ev         ( i_ev.arbiter    )
    );

    fc_irq_line_map i_line_map (
        .req_i      ( core_irq_req    ),
        .id_i       ( core_irq_id     ),
        .fast_o     ( irq_fast_o      ),
        .ack_i      ( irq_ack_i       ),
        .ack_line_i ( irq_ack_line_i  ),
        .ack_o      ( core_irq_ack    ),
        .ack_id_o   ( core_irq_ack_id ),
        .fifo_pop_o ( fifo_pop        )
    );

endmodule

//--- design/fc_irq_line_map.sv
// Translation between event unit ids and the core's fast interrupt lines,
// in both directions. Purely combinational.
module fc_irq_line_map (
    input  logic                   req_i,
    input  fc_irq_pkg::irq_id_t    id_i,
    output fc_irq_pkg::fast_vec_t  fast_o,
    input  logic                   ack_i,
    input  fc_irq_pkg::fast_line_t ack_line_i,
    output logic                   ack_o,
    output fc_irq_pkg::irq_id_t    ack_id_o,
    output logic                   fifo_pop_o
);

    logic ack_is_fifo;

    // id to line
    always_comb begin
        fast_o = '0;
        if (req_i) begin
            if (id_i == fc_irq_pkg::FIFO_IRQ_ID) begin
                fast_o[fc_irq_pkg::FIFO_FAST_LINE] = 1'b1; // SoC event FIFO
            end else if (id_i < fc_irq_pkg::FAST_NUM) begin
                fast_o[fc_irq_pkg::fast_line_t'(id_i)] = 1'b1;
            end
        end
    end

    // line back to id
    assign ack_is_fifo = (ack_line_i == fc_irq_pkg::FIFO_FAST_LINE);

    always_comb begin
        if (ack_is_fifo) begin
            ack_id_o = fc_irq_pkg::FIFO_IRQ_ID;
        end else begin
            ack_id_o = {1'b0, ack_line_i};  // lines 0..14 keep their number
        end
    end

    assign ack_o      = ack_i;
    assign fifo_pop_o = ack_i && ack_is_fifo;

endmodule

//--- design/fc_irq_arbiter.sv
// Pending register of the event unit plus masking and fixed priority
// selection. The lowest active id wins.
module fc_irq_arbiter (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  fc_irq_pkg::irq_vec_t events_i,
    input  logic                 fifo_irq_i,
    input  logic                 ack_i,
    input  fc_irq_pkg::irq_id_t  ack_id_i,
    output logic                 req_o,
    output fc_irq_pkg::irq_id_t  id_o,
    fc_event_if.arbiter          ev
);

    fc_irq_pkg::irq_vec_t pending_q;
    fc_irq_pkg::irq_vec_t ack_clr;
    fc_irq_pkg::irq_vec_t eff_vec;

    //******************************
    // pending register
    //******************************
    // the FIFO id is not cleared here, its ack pops the FIFO
    always_comb begin
        ack_clr = '0;
        if (ack_i && ack_id_i != fc_irq_pkg::FIFO_IRQ_ID) begin
            ack_clr[ack_id_i] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= '0;
        end else begin
            // set wins over clear
            pending_q <= (pending_q & ~(ev.sw_clr | ack_clr)) | events_i | ev.sw_set;
        end
    end

    assign ev.pending = pending_q;

    //******************************
    // masking and selection
    //******************************
    always_comb begin
        eff_vec = pending_q;
        eff_vec[fc_irq_pkg::FIFO_IRQ_ID] = fifo_irq_i; // FIFO occupancy
        eff_vec = eff_vec & ev.mask;
    end

    assign req_o = |eff_vec;

    always_comb begin
        id_o = '0;
        for (int i = fc_irq_pkg::IRQ_NUM - 1; i >= 0; i--) begin
            if (eff_vec[i]) id_o = fc_irq_pkg::irq_id_t'(i);
        end
    end

    // the core may only acknowledge what it was shown
    a_ack_was_active: assert property (
        @(posedge clk_i) disable iff (rst_i) ack_i |-> eff_vec[ack_id_i]
    ) else $error("acknowledge of id %0d which was not active", ack_id_i);

endmodule

//--- design/fc_event_fifo.sv
// Buffer for peripheral event ids. Raises not_empty_o, which the arbiter
// turns into the FIFO interrupt. Pushes while full are dropped.
module fc_event_fifo #(
    parameter int EVENT_FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  push_i,
    input  fc_irq_pkg::event_id_t data_i,
    input  logic                  pop_i,
    output logic                  fulln_o,
    output fc_irq_pkg::event_id_t head_o,
    output logic                  not_empty_o
);

    localparam int PTR_W = $clog2(EVENT_FIFO_DEPTH);

    fc_irq_pkg::event_id_t mem [EVENT_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [PTR_W:0]        count_q;
    logic [PTR_W:0]        count_d;
    logic                  fulln_q;
    logic                  push_ok;
    logic                  pop_ok;

    assign push_ok = push_i && fulln_q;
    assign pop_ok  = pop_i && (count_q != '0);

    always_comb begin
        count_d = count_q;
        case ({push_ok, pop_ok})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;  // both or neither
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            fulln_q  <= 1'b1;
        end else begin
            if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is 2^n
            if (pop_ok)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_d;
            fulln_q <= (count_d != (PTR_W+1)'(EVENT_FIFO_DEPTH));
        end
    end

    // storage, no reset
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    assign head_o      = mem[rd_ptr_q];
    assign not_empty_o = (count_q != '0);
    assign fulln_o     = fulln_q;

    // pop comes from a core acknowledge of the FIFO line
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (rst_i) pop_i |-> not_empty_o
    ) else $error("event FIFO popped while empty");

endmodule

//--- design/fc_event_regs.sv
// Configuration registers of the event unit. Writes and reads are single
// cycle strobes with no wait states; read data shows up one cycle after
// the read strobe and holds until the next read.
module fc_event_regs (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  cfg_we_i,
    input  logic                  cfg_re_i,
    input  fc_irq_pkg::cfg_addr_t cfg_addr_i,
    input  fc_irq_pkg::cfg_data_t cfg_wdata_i,
    output fc_irq_pkg::cfg_data_t cfg_rdata_o,
    input  fc_irq_pkg::event_id_t fifo_head_i,
    input  logic                  fetch_en_i,
    output logic                  fetch_en_o,
    fc_event_if.regs              ev
);

    fc_irq_pkg::irq_vec_t  mask_q;
    fc_irq_pkg::cfg_data_t rdata_q;
    logic                  ctrl_q;
    logic                  ctrl_d;
    logic                  fetch_en_q;

    //******************************
    // write side
    //******************************
    always_comb begin
        ctrl_d = ctrl_q;
        if (cfg_we_i && cfg_addr_i == fc_irq_pkg::REG_CTRL) begin
            ctrl_d = cfg_wdata_i[0];
        end
    end

    // set and clear go straight to the pending register, no extra stage
    assign ev.sw_set = (cfg_we_i && cfg_addr_i == fc_irq_pkg::REG_PENDING)
                       ? cfg_wdata_i : '0;
    assign ev.sw_clr = (cfg_we_i && cfg_addr_i == fc_irq_pkg::REG_PENDING_CLR)
                       ? cfg_wdata_i : '0;
    assign ev.mask   = mask_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask_q     <= '0;
            ctrl_q     <= 1'b1;  // core fetches by default
            fetch_en_q <= 1'b0;
        end else begin
            if (cfg_we_i && cfg_addr_i == fc_irq_pkg::REG_MASK) begin
                mask_q <= cfg_wdata_i & fc_irq_pkg::IRQ_DELIVERABLE;
            end
            ctrl_q     <= ctrl_d;
            fetch_en_q <= fetch_en_i & ctrl_d; // new ctrl value takes effect at once
        end
    end

    assign fetch_en_o = fetch_en_q;

    //******************************
    // read side
    //******************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_q <= '0;
        end else if (cfg_re_i) begin
            case (cfg_addr_i)
                fc_irq_pkg::REG_MASK:      rdata_q <= mask_q;
                fc_irq_pkg::REG_PENDING:   rdata_q <= ev.pending;
                fc_irq_pkg::REG_CTRL:      rdata_q <= {31'b0, ctrl_q};
                fc_irq_pkg::REG_FIFO_HEAD: rdata_q <= {24'b0, fifo_head_i};
                default:                   rdata_q <= '0; // clr is write only
            endcase
        end
    end

    assign cfg_rdata_o = rdata_q;

    // the port has one strobe per cycle
    a_no_rw_collision: assert property (
        @(posedge clk_i) disable iff (rst_i) !(cfg_we_i && cfg_re_i)
    ) else $error("cfg write and read strobes high in the same cycle");

endmodule

//--- design/fc_event_if.sv
// Mask, pending and software set/clear between the register block and
// the arbiter. The register block owns mask and the pulses, the arbiter
// owns pending.
interface fc_event_if;

    fc_irq_pkg::irq_vec_t mask;    // only deliverable bits ever set
    fc_irq_pkg::irq_vec_t sw_set;  // single cycle pulse
    fc_irq_pkg::irq_vec_t sw_clr;  // single cycle pulse
    fc_irq_pkg::irq_vec_t pending;

    modport regs (
        output mask,
        output sw_set,
        output sw_clr,
        input  pending
    );

    modport arbiter (
        input  mask,
        input  sw_set,
        input  sw_clr,
        output pending
    );

endinterface

//--- design/fc_irq_pkg.sv
// Shared types and constants for the fabric controller interrupt path.
// Every block refers to these by scoped name, fc_irq_pkg::name.
package fc_irq_pkg;

    //******************************
    // widths
    //******************************
    localparam int IRQ_NUM      = 32;  // event lines into the event unit
    localparam int IRQ_ID_W     = 5;
    localparam int FAST_NUM     = 15;  // fast interrupt lines on the core
    localparam int FAST_LINE_W  = 4;
    localparam int EVENT_ID_W   = 8;   // peripheral event id width
    localparam int CFG_ADDR_W   = 3;
    localparam int CFG_DATA_W   = 32;

    typedef logic [IRQ_ID_W-1:0]    irq_id_t;
    typedef logic [IRQ_NUM-1:0]     irq_vec_t;
    typedef logic [FAST_LINE_W-1:0] fast_line_t;
    typedef logic [FAST_NUM-1:0]    fast_vec_t;
    typedef logic [EVENT_ID_W-1:0]  event_id_t;
    typedef logic [CFG_ADDR_W-1:0]  cfg_addr_t;
    typedef logic [CFG_DATA_W-1:0]  cfg_data_t;

    //******************************
    // interrupt ids
    //******************************
    // SoC event FIFO sits on id 26 but reaches the core on fast line 10
    localparam irq_id_t    FIFO_IRQ_ID    = 5'd26;
    localparam fast_line_t FIFO_FAST_LINE = 4'd10;

    // ids 0..14 plus the FIFO id, nothing else has a fast line
    localparam irq_vec_t IRQ_DELIVERABLE = 32'h0400_7FFF;

    //******************************
    // register map
    //******************************
    localparam cfg_addr_t REG_MASK        = 3'd0;
    localparam cfg_addr_t REG_PENDING     = 3'd1; // read pending, write sets
    localparam cfg_addr_t REG_PENDING_CLR = 3'd2;
    localparam cfg_addr_t REG_CTRL        = 3'd3; // bit 0 fetch enable
    localparam cfg_addr_t REG_FIFO_HEAD   = 3'd4;

endpackage
